// File: board_glue_config.svh
/*
 * Build-time constants for the board glue logic.
 * Include in any RTL or testbench file that needs clock, RS-485 or reset timing.
 */

`ifndef BOARD_GLUE_CONFIG_SVH
`define BOARD_GLUE_CONFIG_SVH

// System clock in Hz
`define SYS_CLK_FREQ 40000000

// Transceiver switch time of 90 ns plus 10 ns margin
`define RS485_SWITCH_DELAY_NS 100

// Switch delay in clk_sys cycles
// Divide gives whole cycles, plus one to round up
`define RS485_SWITCH_CYCLES \
  ((`RS485_SWITCH_DELAY_NS / (1000000000 / `SYS_CLK_FREQ)) + 1)

// Driver hold after last transmitted bit
`define RS485_TX_END_CYCLES `RS485_SWITCH_CYCLES

// Reset release stretch in clk_sys cycles
`define RST_HOLD_CYCLES 16

// Width of the reset stretch counter, must hold RST_HOLD_CYCLES
`define RST_CNT_W 5

`endif

// File: board_pins_pkg.sv
/*
 * Types for the board pin groups: switches, user LEDs and the trace port.
 * Imported by the pin mapping block and the top level.
 */

package board_pins_pkg;

  // Switch groups, active high after conditioning
  typedef logic [4:0] nav_sw_t;   // Joystick directions and press
  typedef logic [7:0] user_sw_t;  // DIP switches
  typedef logic [2:0] sel_sw_t;   // Software selection

  typedef logic [7:0] user_led_t;

  // Trace header, four pins
  typedef logic [3:0] trace_t;

  // Bit positions of the LCD SPI lines within trace_t
  typedef enum logic [1:0] {
    TRACE_CIPO = 2'd0,  // Data back from LCD
    TRACE_SCLK = 2'd1,
    TRACE_CS   = 2'd2,
    TRACE_COPI = 2'd3   // Data out to LCD
  } trace_bit_e;

endpackage

// File: board_ctrl_pkg.sv
/*
 * State encodings of the reset and RS-485 controllers.
 * Imported by rst_ctrl and rs485_ctrl.
 */

package board_ctrl_pkg;

  // Reset controller
  typedef enum logic [1:0] {
    RST_HOLD,   // Waiting for lock and button release
    RST_COUNT,  // Stretching the release
    RST_RUN     // System out of reset
  } rst_state_e;

  // Half-duplex transceiver sequence
  typedef enum logic [2:0] {
    RS_RX,          // Idle, receiver may listen
    RS_TX_TURN_ON,  // Driver on, line held high
    RS_TX,          // Driver follows tx data
    RS_TX_END,      // Driver still on after last bit
    RS_RX_TURN_ON   // Driver off, receiver not yet on
  } rs485_state_e;

endpackage

// File: rst_ctrl.sv
/*
 * System reset generator. Holds rst_sys_n_o low until the PLL reports lock
 * and the reset button is released, then releases after a counted stretch.
 */

`include "board_glue_config.svh"

module rst_ctrl
  import board_ctrl_pkg::*;
(
  input  logic clk_sys,
  input  logic arst_n_i,      // Reset button, active low
  input  logic pll_locked_i,  // From clock generator, asynchronous
  output logic rst_sys_n_o
);

  localparam int unsigned CNT_W = `RST_CNT_W;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RST_HOLD_CYCLES - 1);

  logic [1:0]       lock_sync_q;  // Two-flop synchroniser
  logic             lock_ok;
  rst_state_e       state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;

  assign lock_ok = lock_sync_q[1];

  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_sync_q <= 2'b00;
    end else begin
      lock_sync_q <= {lock_sync_q[0], pll_locked_i};
    end
  end

  // Next state and stretch counter
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      RST_HOLD: begin
        if (lock_ok) begin
          state_d = RST_COUNT;
          cnt_d   = cnt_q + 1'b1;  // First counted edge
        end
      end
      RST_COUNT: begin
        if (cnt_q == CNT_LAST) state_d = RST_RUN;
        else                   cnt_d   = cnt_q + 1'b1;
      end
      default: ;  // RST_RUN stays put while locked
    endcase
    // Lock loss restarts the whole sequence
    if (!lock_ok) begin
      state_d = RST_HOLD;
      cnt_d   = '0;
    end
  end

  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RST_HOLD;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  assign rst_sys_n_o = (state_q == RST_RUN);  // Button drops it at once via state reset

endmodule

// File: rs485_ctrl.sv
/*
 * RS-485 half-duplex transceiver sequencing. Spaces driver and receiver
 * enables around each transmit burst so both are never on together.
 */

`include "board_glue_config.svh"

module rs485_ctrl
  import board_ctrl_pkg::*;
(
  input  logic clk_sys,
  input  logic arst_n_i,
  input  logic rst_sys_n_i,    // System reset, keeps FSM in RS_RX
  input  logic rs485_tx_i,     // Serial data from system UART
  input  logic rs485_tx_en_i,  // High for the length of a burst
  input  logic rs485_rx_en_i,  // System wants to listen
  input  logic rs485_ro_i,     // Receiver output pin
  output logic rs485_di_o,     // Driver input pin
  output logic rs485_de_o,     // Driver enable, active high
  output logic rs485_ren_o,    // Receiver enable, active low
  output logic rs485_rx_o      // Serial data back to system
);

  // One counter serves both delays
  localparam int unsigned MAX_CYCLES =
    (`RS485_SWITCH_CYCLES > `RS485_TX_END_CYCLES) ? `RS485_SWITCH_CYCLES
                                                  : `RS485_TX_END_CYCLES;
  localparam int unsigned CNT_W = $clog2(MAX_CYCLES + 1);

  // Loaded with count minus one, state exits when counter reaches zero
  localparam logic [CNT_W-1:0] SWITCH_LOAD = CNT_W'(`RS485_SWITCH_CYCLES - 1);
  localparam logic [CNT_W-1:0] TX_END_LOAD = CNT_W'(`RS485_TX_END_CYCLES - 1);

  rs485_state_e     state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic             cnt_done;

  assign cnt_done = (cnt_q == '0);

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      RS_RX: begin
        if (rs485_tx_en_i) begin
          state_d = RS_TX_TURN_ON;
          cnt_d   = SWITCH_LOAD;
        end
      end
      RS_TX_TURN_ON: begin
        if (cnt_done) state_d = RS_TX;  // Driver settled
        else          cnt_d   = cnt_q - 1'b1;
      end
      RS_TX: begin
        if (!rs485_tx_en_i) begin
          state_d = RS_TX_END;
          cnt_d   = TX_END_LOAD;
        end
      end
      RS_TX_END: begin
        if (cnt_done) begin
          state_d = RS_RX_TURN_ON;
          cnt_d   = SWITCH_LOAD;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      RS_RX_TURN_ON: begin
        // A new burst request waits until back in RS_RX
        if (cnt_done) state_d = RS_RX;
        else          cnt_d   = cnt_q - 1'b1;
      end
      default: state_d = RS_RX;  // Unused encodings
    endcase
    if (!rst_sys_n_i) begin
      state_d = RS_RX;
      cnt_d   = '0;
    end
  end

  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RS_RX;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Pin drive decoded from registered state
  always_comb begin
    rs485_de_o  = 1'b0;
    rs485_ren_o = 1'b1;  // Receiver off unless idle and enabled
    rs485_di_o  = 1'b1;  // Line idles high
    rs485_rx_o  = 1'b1;
    case (state_q)
      RS_RX: begin
        rs485_ren_o = ~rs485_rx_en_i;
        if (rs485_rx_en_i) rs485_rx_o = rs485_ro_i;
      end
      RS_TX_TURN_ON, RS_TX_END: rs485_de_o = 1'b1;
      RS_TX: begin
        rs485_de_o = 1'b1;
        rs485_di_o = rs485_tx_i;
      end
      default: ;  // RS_RX_TURN_ON keeps both off
    endcase
  end

endmodule

// File: board_pin_map.sv
/*
 * Board pin conditioning. Inverts and registers the active-low switches,
 * maps status LEDs and copies LCD SPI traffic onto the trace header.
 */

module board_pin_map
  import board_pins_pkg::*;
(
  input  logic      clk_sys,
  input  logic      arst_n_i,
  input  logic      rst_sys_n_i,
  // Switch pins, pulled up, low when pressed
  input  nav_sw_t   nav_sw_i,
  input  user_sw_t  user_sw_i,
  input  sel_sw_t   sel_sw_i,
  // From system
  input  user_led_t user_led_i,
  input  logic      rgbled_dout_i,
  input  logic      cheri_en_i,
  input  logic      lcd_copi_i,
  input  logic      lcd_cs_i,
  input  logic      lcd_sclk_i,
  input  logic      lcd_cipo_i,
  // Conditioned switches, 1 when pressed
  output nav_sw_t   nav_sw_o,
  output user_sw_t  user_sw_o,
  output sel_sw_t   sel_sw_o,
  // Board LEDs and trace header
  output user_led_t usr_led_o,
  output logic      led_bootok_o,
  output logic      led_cheri_o,
  output logic      led_legacy_o,
  output logic      rgbled_o,
  output trace_t    trace_o
);

  nav_sw_t  nav_sw_q;
  user_sw_t user_sw_q;
  sel_sw_t  sel_sw_q;
  trace_t   trace_q;

  // Switch capture
  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      nav_sw_q  <= '0;
      user_sw_q <= '0;
      sel_sw_q  <= '0;
    end else begin
      nav_sw_q  <= ~nav_sw_i;
      user_sw_q <= ~user_sw_i;
      sel_sw_q  <= ~sel_sw_i;
    end
  end

  // LCD SPI snapshot for an external analyser
  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trace_q <= '0;
    end else begin
      trace_q[TRACE_COPI] <= lcd_copi_i;  // Controller output
      trace_q[TRACE_CS]   <= lcd_cs_i;
      trace_q[TRACE_SCLK] <= lcd_sclk_i;
      trace_q[TRACE_CIPO] <= lcd_cipo_i;  // Read back from LCD
    end
  end

  assign nav_sw_o  = nav_sw_q;
  assign user_sw_o = user_sw_q;
  assign sel_sw_o  = sel_sw_q;
  assign trace_o   = trace_q;

  // Status LEDs
  assign led_bootok_o = rst_sys_n_i;  // Lit once system is out of reset
  assign led_cheri_o  = cheri_en_i;
  assign led_legacy_o = ~cheri_en_i;
  assign usr_led_o    = user_led_i;

  // RGB LED data line is inverted by the board level shifter
  assign rgbled_o = ~rgbled_dout_i;

endmodule

// File: board_top.sv
/*
 * Board glue top level between the processor system and the pins.
 * System-side signals arrive as plain inputs; instantiate in place of the pad logic.
 */

module board_top
  import board_pins_pkg::*;
(
  input  logic      clk_sys,
  input  logic      arst_n_i,       // Reset button
  input  logic      pll_locked_i,
  output logic      rst_sys_n_o,    // System reset out

  // RS-485, system side
  input  logic      rs485_tx_i,
  input  logic      rs485_tx_en_i,
  input  logic      rs485_rx_en_i,
  output logic      rs485_rx_o,
  // RS-485, transceiver pins
  input  logic      rs485_ro_i,
  output logic      rs485_di_o,
  output logic      rs485_de_o,
  output logic      rs485_ren_o,

  // Switch pins
  input  nav_sw_t   nav_sw_i,
  input  user_sw_t  user_sw_i,
  input  sel_sw_t   sel_sw_i,
  // System outputs for LEDs and LCD
  input  user_led_t user_led_i,
  input  logic      rgbled_dout_i,
  input  logic      cheri_en_i,
  input  logic      lcd_copi_i,
  input  logic      lcd_cs_i,
  input  logic      lcd_sclk_i,
  input  logic      lcd_cipo_i,

  // Conditioned switches to system
  output nav_sw_t   nav_sw_o,
  output user_sw_t  user_sw_o,
  output sel_sw_t   sel_sw_o,
  // Board LEDs and trace header
  output user_led_t usr_led_o,
  output logic      led_bootok_o,
  output logic      led_cheri_o,
  output logic      led_legacy_o,
  output logic      rgbled_o,
  output trace_t    trace_o
);

  logic rst_sys_n;  // Counted system reset

  rst_ctrl u_rst_ctrl (
    .clk_sys      (clk_sys),
    .arst_n_i     (arst_n_i),
    .pll_locked_i (pll_locked_i),
    .rst_sys_n_o  (rst_sys_n)
  );

  assign rst_sys_n_o = rst_sys_n;

  rs485_ctrl u_rs485_ctrl (
    .clk_sys       (clk_sys),
    .arst_n_i      (arst_n_i),
    .rst_sys_n_i   (rst_sys_n),
    .rs485_tx_i    (rs485_tx_i),
    .rs485_tx_en_i (rs485_tx_en_i),
    .rs485_rx_en_i (rs485_rx_en_i),
    .rs485_ro_i    (rs485_ro_i),
    .rs485_di_o    (rs485_di_o),
    .rs485_de_o    (rs485_de_o),
    .rs485_ren_o   (rs485_ren_o),
    .rs485_rx_o    (rs485_rx_o)
  );

  // Switches, LEDs and trace
  board_pin_map u_pin_map (
    .clk_sys       (clk_sys),
    .arst_n_i      (arst_n_i),
    .rst_sys_n_i   (rst_sys_n),
    .nav_sw_i      (nav_sw_i),
    .user_sw_i     (user_sw_i),
    .sel_sw_i      (sel_sw_i),
    .user_led_i    (user_led_i),
    .rgbled_dout_i (rgbled_dout_i),
    .cheri_en_i    (cheri_en_i),
    .lcd_copi_i    (lcd_copi_i),
    .lcd_cs_i      (lcd_cs_i),
    .lcd_sclk_i    (lcd_sclk_i),
    .lcd_cipo_i    (lcd_cipo_i),
    .nav_sw_o      (nav_sw_o),
    .user_sw_o     (user_sw_o),
    .sel_sw_o      (sel_sw_o),
    .usr_led_o     (usr_led_o),
    .led_bootok_o  (led_bootok_o),
    .led_cheri_o   (led_cheri_o),
    .led_legacy_o  (led_legacy_o),
    .rgbled_o      (rgbled_o),
    .trace_o       (trace_o)
  );

endmodule

// File: board_top_chk.sv
/*
 * Assertions on the RS-485 pins and system reset of board_top.
 * Attached to every board_top by the bind at the end of this file.
 */

`include "board_glue_config.svh"

module board_top_chk (
  input logic clk_sys,
  input logic arst_n_i,
  input logic rst_sys_n_i,
  input logic de_i,   // Driver enable pin
  input logic ren_i,  // Receiver enable pin, active low
  input logic di_i    // Driver data pin
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // Read by the testbench at the end
  int unsigned de_age;        // Edges with driver enabled in a row

  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      de_age <= 0;
    end else if (!de_i) begin
      de_age <= 0;
    end else if (de_age < 1000) begin
      de_age <= de_age + 1;  // Saturates well past the turn-on window
    end
  end

  // Receiver must be off while the driver is on
  assert property (@(posedge clk_sys) disable iff (!arst_n_i) de_i |-> ren_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("driver enabled with receiver on");
    end

  // Line held idle high through the whole driver turn-on
  assert property (@(posedge clk_sys) disable iff (!arst_n_i)
    (de_i && de_age < `RS485_SWITCH_CYCLES) |-> di_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("driver data not idle during turn-on");
    end

  // FSM sees the system reset one edge later
  assert property (@(posedge clk_sys) disable iff (!arst_n_i) !rst_sys_n_i |=> !de_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("driver enabled during system reset");
    end

endmodule

bind board_top board_top_chk u_chk (
  .clk_sys     (clk_sys),
  .arst_n_i    (arst_n_i),
  .rst_sys_n_i (rst_sys_n_o),
  .de_i        (rs485_de_o),
  .ren_i       (rs485_ren_o),
  .di_i        (rs485_di_o)
);

// File: tb_board_top.sv
/*
 * Testbench for board_top. Seeded random pins and RS-485 bursts,
 * checked every cycle against a cycle model; reset timing checked by bounded waits.
 */

`include "board_glue_config.svh"

module tb_board_top
  import board_pins_pkg::*, board_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SW_CYC     = `RS485_SWITCH_CYCLES;
  localparam int unsigned END_CYC    = `RS485_TX_END_CYCLES;
  localparam int unsigned HOLD       = `RST_HOLD_CYCLES;
  localparam int unsigned WAIT_LIMIT = 40;    // Per wait, in cycles
  localparam int unsigned RUN_CYCLES = 3000;

  // DUT inputs, idle values until stimulus starts
  logic      clk_sys       = 1'b0;
  logic      arst_n_i      = 1'b0;
  logic      pll_locked_i  = 1'b1;
  logic      rs485_tx_i    = 1'b1;
  logic      rs485_tx_en_i = 1'b0;
  logic      rs485_rx_en_i = 1'b0;
  logic      rs485_ro_i    = 1'b1;
  nav_sw_t   nav_sw_i      = '1;   // Switches released
  user_sw_t  user_sw_i     = '1;
  sel_sw_t   sel_sw_i      = '1;
  user_led_t user_led_i    = '0;
  logic      rgbled_dout_i = 1'b0;
  logic      cheri_en_i    = 1'b0;
  logic      lcd_copi_i    = 1'b0;
  logic      lcd_cs_i      = 1'b1;
  logic      lcd_sclk_i    = 1'b0;
  logic      lcd_cipo_i    = 1'b0;

  logic      rst_sys_n_o, rs485_rx_o, rs485_di_o, rs485_de_o, rs485_ren_o;
  nav_sw_t   nav_sw_o;
  user_sw_t  user_sw_o;
  sel_sw_t   sel_sw_o;
  user_led_t usr_led_o;
  logic      led_bootok_o, led_cheri_o, led_legacy_o, rgbled_o;
  trace_t    trace_o;

  int unsigned chk_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned tmo_cnt = 0;
  logic        stim_en  = 1'b0;
  logic        burst_en = 1'b0;
  int unsigned run_left = 0;   // Cycles until tx_en toggles
  logic        rst_known = 1'b1;  // Reset level settled, no release or drop pending
  logic        rst_exp   = 1'b0;

  // Model state
  rs485_state_e m_state;
  int unsigned  m_cnt;      // Cycles spent in current state
  nav_sw_t      exp_nav;
  user_sw_t     exp_user;
  sel_sw_t      exp_sel;
  trace_t       exp_trace;

  board_top uut (.*);

  always #10 clk_sys = ~clk_sys;

  always @(posedge clk_sys) begin : drive_inputs
    logic [31:0] r;
    logic [31:0] s;
    r = $urandom;
    s = $urandom;
    if (stim_en) begin
      nav_sw_i      <= r[4:0];
      user_sw_i     <= r[12:5];
      sel_sw_i      <= r[15:13];
      user_led_i    <= r[23:16];
      rgbled_dout_i <= r[24];
      cheri_en_i    <= r[25];
      lcd_copi_i    <= r[26];
      lcd_cs_i      <= r[27];
      lcd_sclk_i    <= r[28];
      lcd_cipo_i    <= r[29];
      rs485_ro_i    <= r[30];
      rs485_rx_en_i <= r[31];
      rs485_tx_i    <= s[0];
    end
    if (burst_en) begin
      // Bursts and gaps of random length
      if (run_left == 0) begin
        rs485_tx_en_i <= ~rs485_tx_en_i;
        run_left      <= $urandom_range(24, 1);
      end else begin
        run_left <= run_left - 1;
      end
    end else begin
      rs485_tx_en_i <= 1'b0;
      run_left      <= 0;
    end
  end

  // Cycle model of transceiver sequence and register lag
  always @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      m_state   <= RS_RX;
      m_cnt     <= 0;
      exp_nav   <= '0;
      exp_user  <= '0;
      exp_sel   <= '0;
      exp_trace <= '0;
    end else begin
      exp_nav   <= ~nav_sw_i;  // Pressed reads 1
      exp_user  <= ~user_sw_i;
      exp_sel   <= ~sel_sw_i;
      exp_trace[TRACE_COPI] <= lcd_copi_i;
      exp_trace[TRACE_CS]   <= lcd_cs_i;
      exp_trace[TRACE_SCLK] <= lcd_sclk_i;
      exp_trace[TRACE_CIPO] <= lcd_cipo_i;
      m_cnt <= m_cnt + 1;
      case (m_state)
        RS_RX: begin
          if (rs485_tx_en_i) begin
            m_state <= RS_TX_TURN_ON;
            m_cnt   <= 0;
          end
        end
        RS_TX_TURN_ON: begin
          if (m_cnt == SW_CYC - 1) begin
            m_state <= RS_TX;
            m_cnt   <= 0;
          end
        end
        RS_TX: begin
          if (!rs485_tx_en_i) begin
            m_state <= RS_TX_END;
            m_cnt   <= 0;
          end
        end
        RS_TX_END: begin
          if (m_cnt == END_CYC - 1) begin
            m_state <= RS_RX_TURN_ON;
            m_cnt   <= 0;
          end
        end
        default: begin
          if (m_cnt == SW_CYC - 1) begin  // Tx requests ignored until back in RX
            m_state <= RS_RX;
            m_cnt   <= 0;
          end
        end
      endcase
      if (!rst_sys_n_o) begin  // Held in receive during system reset
        m_state <= RS_RX;
        m_cnt   <= 0;
      end
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk_sys) begin : compare_outputs
    logic exp_de;
    logic exp_ren;
    logic exp_di;
    logic exp_rx;
    logic exp_legacy;
    logic exp_rgb;
    exp_de     = (m_state == RS_TX_TURN_ON) || (m_state == RS_TX) || (m_state == RS_TX_END);
    exp_ren    = (m_state == RS_RX) ? ~rs485_rx_en_i : 1'b1;
    exp_di     = (m_state == RS_TX) ? rs485_tx_i : 1'b1;
    exp_rx     = (m_state == RS_RX && rs485_rx_en_i) ? rs485_ro_i : 1'b1;
    exp_legacy = ~cheri_en_i;
    exp_rgb    = ~rgbled_dout_i;
    compare_value("rs485_de_o", 32'(rs485_de_o), 32'(exp_de));
    compare_value("rs485_ren_o", 32'(rs485_ren_o), 32'(exp_ren));
    compare_value("rs485_di_o", 32'(rs485_di_o), 32'(exp_di));
    compare_value("rs485_rx_o", 32'(rs485_rx_o), 32'(exp_rx));
    compare_value("nav_sw_o", 32'(nav_sw_o), 32'(exp_nav));
    compare_value("user_sw_o", 32'(user_sw_o), 32'(exp_user));
    compare_value("sel_sw_o", 32'(sel_sw_o), 32'(exp_sel));
    compare_value("trace_o", 32'(trace_o), 32'(exp_trace));
    compare_value("usr_led_o", 32'(usr_led_o), 32'(user_led_i));
    compare_value("led_cheri_o", 32'(led_cheri_o), 32'(cheri_en_i));
    compare_value("led_legacy_o", 32'(led_legacy_o), 32'(exp_legacy));
    compare_value("rgbled_o", 32'(rgbled_o), 32'(exp_rgb));
    if (rst_known) begin  // Steady reset level between windows
      compare_value("rst_sys_n_o", 32'(rst_sys_n_o), 32'(rst_exp));
      compare_value("led_bootok_o", 32'(led_bootok_o), 32'(rst_exp));
    end
  end

  // Cycles counted from the edge that changed the input
  task automatic wait_reset_level(input logic level, input int unsigned lo,
                                  input int unsigned hi);
    int unsigned n;
    logic        seen;
    n         = 0;
    seen      = 1'b0;
    rst_known = 1'b0;
    while (!seen && n < WAIT_LIMIT) begin
      @(negedge clk_sys);
      if (rst_sys_n_o === level) seen = 1'b1;
      else n++;
    end
    if (!seen) begin
      tmo_cnt++;
      $display("Timeout at %0t ns: rst_sys_n_o never went to %b", $time, level);
    end else begin
      if (n < lo || n > hi) begin
        err_cnt++;
        $display("At %0t ns rst_sys_n_o went to %b after %0d cycles, allowed %0d to %0d",
                 $time, level, n, lo, hi);
      end
      compare_value("led_bootok_o", 32'(led_bootok_o), 32'(level));
      rst_exp   = level;
      rst_known = 1'b1;
    end
  endtask

  task automatic wait_rs485_idle();
    int unsigned n;
    logic        idle;
    n    = 0;
    idle = 1'b0;
    while (!idle && n < WAIT_LIMIT) begin
      @(negedge clk_sys);
      n++;
      idle = (m_state == RS_RX);
    end
    if (!idle) begin
      tmo_cnt++;
      $display("Timeout at %0t ns: transceiver did not return to receive", $time);
    end
  endtask

  initial begin : run_test
    int unsigned k;
    void'($urandom(3));
    repeat (4) @(posedge clk_sys);
    arst_n_i <= 1'b1;
    wait_reset_level(1'b1, HOLD, HOLD + 3);  // Includes the lock synchroniser
    stim_en  = 1'b1;
    burst_en = 1'b1;
    repeat (RUN_CYCLES) @(posedge clk_sys);
    // Lock drops of random spacing and length, bursts keep running
    repeat (4) begin
      k = $urandom_range(30, 5);
      repeat (k) @(posedge clk_sys);
      pll_locked_i <= 1'b0;
      wait_reset_level(1'b0, 0, 3);
      k = $urandom_range(4, 1);
      repeat (k) @(posedge clk_sys);
      pll_locked_i <= 1'b1;
      wait_reset_level(1'b1, HOLD, HOLD + 3);
    end
    repeat (300) @(posedge clk_sys);  // Traffic after recovery
    @(negedge clk_sys);
    burst_en = 1'b0;
    stim_en  = 1'b0;
    wait_rs485_idle();
    $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             chk_cnt, err_cnt, tmo_cnt, uut.u_chk.fail_cnt);
    if (err_cnt == 0 && tmo_cnt == 0 && uut.u_chk.fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #200000;
    $display("Simulation did not finish within 200 us");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: board_top.f
+incdir+.
board_pins_pkg.sv
board_ctrl_pkg.sv
rst_ctrl.sv
rs485_ctrl.sv
board_pin_map.sv
board_top.sv
board_top_chk.sv
tb_board_top.sv

// File: Makefile
# Verilator build and run of the board glue testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module tb_board_top -f board_top.f -o sim_board_top
	-./obj_dir/sim_board_top +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "Test did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
